/* zynq_ctrl.f */
+incdir+bench
hdl/zynq_ctrl_pkg.sv
hdl/word_fifo.sv
hdl/reset_delay_chain.sv
hdl/config_rom.sv
hdl/dram_addr_remap.sv
hdl/axil_csr_slave.sv
hdl/zynq_ctrl_top.sv
bench/zynq_ctrl_tb.sv

/* Bender.yml */
package:
  name: zynq_ctrl

sources:
  - files:
      - hdl/zynq_ctrl_pkg.sv
      - hdl/word_fifo.sv
      - hdl/reset_delay_chain.sv
      - hdl/config_rom.sv
      - hdl/dram_addr_remap.sv
      - hdl/axil_csr_slave.sv
      - hdl/zynq_ctrl_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/zynq_ctrl_tb.sv

/* bench/axil_host_tasks.svh */
`ifndef axil_host_tasks_svh
`define axil_host_tasks_svh

// gp0 master side, included inside the testbench module

// aw and w are offered together, then the response is taken once it shows
task automatic axil_write(input axil_addr_t addr, input word_t data, output axil_resp_t resp);
  int   waited;
  logic fired;
  waited        = 0;
  fired         = 1'b0;
  resp          = resp_slverr_c;
  gp0_awaddr_i  = addr;
  gp0_wdata_i   = data;
  gp0_awvalid_i = 1'b1;
  gp0_wvalid_i  = 1'b1;
  while (!fired && waited < handshake_limit_lp)
    begin
      @(negedge aclk);
      fired       = gp0_awready_o;
      check_level(gp0_wready_o, fired, "write data ready with address ready");
      // the handshake edge is the coming rising edge
      wr_hs_cycle = cycle_cnt + 1;
      next_cycle();
      waited++;
    end
  gp0_awvalid_i = 1'b0;
  gp0_wvalid_i  = 1'b0;
  if (!fired)
    begin
      errors++;
      $display("write to address %h was never accepted by the DUT", addr);
    end
  else
    begin
      gp0_bready_i = 1'b1;
      fired        = 1'b0;
      waited       = 0;
      while (!fired && waited < handshake_limit_lp)
        begin
          @(negedge aclk);
          fired = gp0_bvalid_o;
          resp  = gp0_bresp_o;
          next_cycle();
          waited++;
        end
      gp0_bready_i = 1'b0;
      if (!fired)
        begin
          errors++;
          $display("write response for address %h never arrived", addr);
        end
    end
endtask

task automatic axil_read(input axil_addr_t addr, output word_t data, output axil_resp_t resp);
  int   waited;
  logic fired;
  waited        = 0;
  fired         = 1'b0;
  data          = '0;
  resp          = resp_slverr_c;
  gp0_araddr_i  = addr;
  gp0_arvalid_i = 1'b1;
  while (!fired && waited < handshake_limit_lp)
    begin
      @(negedge aclk);
      fired = gp0_arready_o;
      next_cycle();
      waited++;
    end
  gp0_arvalid_i = 1'b0;
  if (!fired)
    begin
      errors++;
      $display("read of address %h was never accepted by the DUT", addr);
    end
  else
    begin
      gp0_rready_i = 1'b1;
      fired        = 1'b0;
      waited       = 0;
      while (!fired && waited < handshake_limit_lp)
        begin
          @(negedge aclk);
          fired = gp0_rvalid_o;
          data  = gp0_rdata_o;
          resp  = gp0_rresp_o;
          next_cycle();
          waited++;
        end
      gp0_rready_i = 1'b0;
      if (!fired)
        begin
          errors++;
          $display("read data for address %h never arrived", addr);
        end
    end
endtask

task automatic write_expect(input axil_addr_t addr, input word_t data,
                            input axil_resp_t exp_resp, input string what);
  axil_resp_t resp;
  axil_write(addr, data, resp);
  check_resp(resp, exp_resp, {what, " response"});
endtask

task automatic read_expect(input axil_addr_t addr, input word_t exp_data,
                           input axil_resp_t exp_resp, input string what);
  word_t      data;
  axil_resp_t resp;
  axil_read(addr, data, resp);
  check_word(data, exp_data, {what, " data"});
  check_resp(resp, exp_resp, {what, " response"});
endtask

`endif

/* bench/zynq_ctrl_tb.sv */
module zynq_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import zynq_ctrl_pkg::*;

  localparam int fifo_els_lp        = 4;
  localparam int reset_depth_lp     = 3;
  localparam int clk_period_lp      = 40;
  localparam int reset_cycles_lp    = 16;
  localparam int num_tests_lp       = 6;
  localparam int cycles_per_test_lp = 200;
  localparam int handshake_limit_lp = 50;

  logic       aclk;
  logic       arst_n_i;
  axil_addr_t gp0_awaddr_i, gp0_araddr_i;
  logic       gp0_awvalid_i, gp0_awready_o, gp0_wvalid_i, gp0_wready_o;
  word_t      gp0_wdata_i, gp0_rdata_o;
  axil_resp_t gp0_bresp_o, gp0_rresp_o;
  logic       gp0_bvalid_o, gp0_bready_i;
  logic       gp0_arvalid_i, gp0_arready_o, gp0_rvalid_o, gp0_rready_i;
  word_t      host_req_data_o, mc_req_data_i;
  logic       host_req_v_o, host_req_ready_i;
  logic       mc_req_v_i, mc_req_ready_o;
  cache_id_t  dma_aw_cache_id_i, dma_ar_cache_id_i;
  llc_addr_t  dma_aw_addr_i, dma_ar_addr_i;
  logic       dma_aw_v_i, dma_aw_ready_o, dma_ar_v_i, dma_ar_ready_o;
  hp_addr_t   hp0_awaddr_o, hp0_araddr_o;
  logic       hp0_awvalid_o, hp0_awready_i, hp0_arvalid_o, hp0_arready_i;
  logic       sys_reset_n_o;

  integer     seed              = 90081;
  int         errors            = 0;
  int         checks            = 0;
  int         tests_run         = 0;
  int         errors_at_start   = 0;
  int         cycle_cnt         = 0;
  int         wr_hs_cycle       = 0;
  int         reset_rise_cycle  = -1;
  logic       host_ready_random = 1'b0;

  // queue models of both fifos and the push responses they predict
  word_t      host_q [$];
  word_t      l2p_q [$];
  axil_resp_t bresp_q [$];

  zynq_ctrl_top
   #(.fifo_els_p(fifo_els_lp)
     ,.reset_depth_p(reset_depth_lp)
     )
   zynq_ctrl_top_inst
    (.*);

  initial
    begin
      aclk = 1'b0;
      forever #(clk_period_lp / 2) aclk = ~aclk;
    end

  always @(posedge aclk)
    cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////
  // compare tasks and reference functions
  //////////////////////////////////////////////////

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    checks++;
    if (actual !== expected)
      begin
        errors++;
        $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end
  endtask

  task automatic check_resp(input axil_resp_t actual, input axil_resp_t expected,
                            input string what);
    checks++;
    if (actual !== expected)
      begin
        errors++;
        $display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      end
  endtask

  task automatic check_addr(input hp_addr_t actual, input hp_addr_t expected, input string what);
    checks++;
    if (actual !== expected)
      begin
        errors++;
        $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      end
  endtask

  task automatic check_level(input logic actual, input logic expected, input string what);
    checks++;
    if (actual !== expected)
      begin
        errors++;
        $display("Fail at %0t ns: %s, got %b, expected %b", $time, what, actual, expected);
      end
  endtask

  function automatic axil_addr_t reg_addr(input reg_idx_t idx);
    return {idx, 2'b00};
  endfunction

  // b5, then the index, then index squared plus one
  function automatic word_t expected_rom(input int k);
    word_t w;
    w[31:24] = 8'hb5;
    w[23:16] = k[7:0];
    w[15:0]  = 16'(k * k + 1);
    return w;
  endfunction

  function automatic hp_addr_t expected_hp_addr(input cache_id_t id, input llc_addr_t addr,
                                                input hp_addr_t base);
    hp_addr_t hashed;
    hashed = '0;
    hashed[llc_addr_width_c-1 -: lg_num_dma_c] = id;
    hashed[llc_addr_width_c-lg_num_dma_c-1:0]  = addr[llc_addr_width_c-lg_num_dma_c-1:0];
    return hashed + base;
  endfunction

  function automatic word_t expected_status();
    return word_t'({host_q.size() < fifo_els_lp, l2p_q.size() != 0});
  endfunction

  //////////////////////////////////////////////////
  // drivers and monitors
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge aclk);
    #2;
    if (host_ready_random)
      host_req_ready_i = 1'($random(seed));
  endtask

  `include "axil_host_tasks.svh"

  // drain is popped before a push is judged, the fifo sees its old count
  always @(negedge aclk)
    begin : host_side_monitor
      logic room;
      logic push_try;
      room     = host_q.size() < fifo_els_lp;
      push_try = gp0_awvalid_i && gp0_wvalid_i && gp0_awready_o
                 && (gp0_awaddr_i[axil_addr_width_c-1:2] == reg_ps_to_pl_c);
      if (arst_n_i && host_req_v_o && host_req_ready_i)
        begin
          if (host_q.size() == 0)
            begin
              errors++;
              $display("host request port sent a word that was never pushed");
            end
          else
            check_word(host_req_data_o, host_q.pop_front(), "host request word order");
        end
      if (arst_n_i && push_try)
        begin
          if (room)
            host_q.push_back(gp0_wdata_i);
          bresp_q.push_back(room ? resp_okay_c : resp_slverr_c);
        end
    end

  always @(negedge aclk)
    if (arst_n_i && sys_reset_n_o && reset_rise_cycle < 0)
      reset_rise_cycle = cycle_cnt;

  task automatic push_word(input word_t data, output axil_resp_t resp);
    axil_write(reg_addr(reg_ps_to_pl_c), data, resp);
    if (bresp_q.size() == 0)
      begin
        errors++;
        $display("push response arrived with no recorded write handshake");
      end
    else
      check_resp(resp, bresp_q.pop_front(), "ps to pl push response");
  endtask

  task automatic send_mc_word(input word_t data);
    int   waited;
    logic taken;
    waited        = 0;
    taken         = 1'b0;
    mc_req_data_i = data;
    mc_req_v_i    = 1'b1;
    while (!taken && waited < handshake_limit_lp)
      begin
        @(negedge aclk);
        taken = mc_req_ready_o;
        next_cycle();
        waited++;
      end
    mc_req_v_i = 1'b0;
    if (taken)
      l2p_q.push_back(data);
    else
      begin
        errors++;
        $display("manycore request word was never accepted");
      end
  endtask

  task automatic pop_and_check();
    word_t      exp_data;
    axil_resp_t exp_resp;
    exp_data = '0;
    exp_resp = resp_slverr_c;
    if (l2p_q.size() != 0)
      begin
        exp_data = l2p_q.pop_front();
        exp_resp = resp_okay_c;
      end
    read_expect(reg_addr(reg_pl_to_ps_c), exp_data, exp_resp, "pl to ps pop");
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name,
             (errors == errors_at_start) ? "ok" : "errors found");
    errors_at_start = errors;
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  initial
    begin : stimulus
      word_t      base;
      axil_resp_t resp;
      int         waited;
      arst_n_i          = 1'b0;
      gp0_awaddr_i      = '0;
      gp0_awvalid_i     = 1'b0;
      gp0_wdata_i       = '0;
      gp0_wvalid_i      = 1'b0;
      gp0_bready_i      = 1'b0;
      gp0_araddr_i      = '0;
      gp0_arvalid_i     = 1'b0;
      gp0_rready_i      = 1'b0;
      host_req_ready_i  = 1'b0;
      mc_req_data_i     = '0;
      mc_req_v_i        = 1'b0;
      dma_aw_cache_id_i = '0;
      dma_aw_addr_i     = '0;
      dma_aw_v_i        = 1'b0;
      dma_ar_cache_id_i = '0;
      dma_ar_addr_i     = '0;
      dma_ar_v_i        = 1'b0;
      hp0_awready_i     = 1'b0;
      hp0_arready_i     = 1'b0;
      repeat (reset_cycles_lp) @(posedge aclk);
      #2;
      arst_n_i = 1'b1;
      next_cycle();

      base = $random(seed);
      write_expect(reg_addr(reg_dram_base_c), base, resp_okay_c, "dram base write");
      read_expect(reg_addr(reg_dram_base_c), base, resp_okay_c, "dram base readback");
      base = $random(seed);
      write_expect(reg_addr(reg_rom_addr_c), base, resp_okay_c, "rom address write");
      read_expect(reg_addr(reg_rom_addr_c), base, resp_okay_c, "rom address readback");
      write_expect(reg_addr(reg_idx_t'(7)), $random(seed), resp_okay_c, "unmapped write");
      read_expect(reg_addr(reg_idx_t'(7)), '0, resp_okay_c, "unmapped read");
      read_expect(reg_addr(reg_idx_t'(8'hff)), '0, resp_okay_c, "top unmapped read");
      finish_test("register readback");

      for (int k = 0; k < rom_els_c; k++)
        begin
          write_expect(reg_addr(reg_rom_addr_c), word_t'(k), resp_okay_c, "rom select");
          read_expect(reg_addr(reg_rom_data_c), expected_rom(k), resp_okay_c, "rom entry");
        end
      finish_test("configuration rom");

      check_level(sys_reset_n_o, 1'b0, "system reset before release");
      write_expect(reg_addr(reg_ctrl_c), 32'h1, resp_okay_c, "control write");
      waited = 0;
      while (reset_rise_cycle < 0 && waited < handshake_limit_lp)
        begin
          next_cycle();
          waited++;
        end
      if (reset_rise_cycle < 0)
        begin
          errors++;
          $display("system reset was never released after the control write");
        end
      else
        check_word(word_t'(reset_rise_cycle - wr_hs_cycle), word_t'(reset_depth_lp),
                   "system reset release delay");
      read_expect(reg_addr(reg_ctrl_c), 32'h1, resp_okay_c, "control readback");
      finish_test("reset delay");

      host_ready_random = 1'b1;
      repeat (12) push_word($random(seed), resp);
      host_ready_random = 1'b0;
      host_req_ready_i  = 1'b0;
      // with the host stalled, one push more than the depth must overflow
      repeat (fifo_els_lp + 1) push_word($random(seed), resp);
      check_resp(resp, resp_slverr_c, "push into a full fifo");
      read_expect(reg_addr(reg_fifo_status_c), expected_status(), resp_okay_c, "full status");
      host_req_ready_i = 1'b1;
      waited = 0;
      while (host_q.size() != 0 && waited < handshake_limit_lp)
        begin
          next_cycle();
          waited++;
        end
      if (host_q.size() != 0)
        begin
          errors++;
          $display("host request port stopped draining the ps to pl fifo");
        end
      read_expect(reg_addr(reg_fifo_status_c), expected_status(), resp_okay_c, "drained status");
      finish_test("ps to pl fifo");

      check_level(mc_req_ready_o, 1'b1, "manycore ready while empty");
      read_expect(reg_addr(reg_fifo_status_c), expected_status(), resp_okay_c, "empty status");
      repeat (fifo_els_lp) send_mc_word($random(seed));
      @(negedge aclk);
      check_level(mc_req_ready_o, l2p_q.size() < fifo_els_lp, "manycore ready when full");
      next_cycle();
      read_expect(reg_addr(reg_fifo_status_c), expected_status(), resp_okay_c, "holding status");
      repeat (fifo_els_lp + 1) pop_and_check();
      read_expect(reg_addr(reg_fifo_status_c), expected_status(), resp_okay_c, "popped status");
      finish_test("pl to ps fifo");

      for (int i = 0; i < 8; i++)
        begin
          base = $random(seed);
          write_expect(reg_addr(reg_dram_base_c), base, resp_okay_c, "dram base write");
          dma_aw_cache_id_i = cache_id_t'($random(seed));
          dma_aw_addr_i     = llc_addr_t'($random(seed));
          dma_ar_cache_id_i = cache_id_t'($random(seed));
          dma_ar_addr_i     = llc_addr_t'($random(seed));
          dma_aw_v_i        = 1'($random(seed));
          dma_ar_v_i        = 1'($random(seed));
          hp0_awready_i     = 1'($random(seed));
          hp0_arready_i     = 1'($random(seed));
          @(negedge aclk);
          check_addr(hp0_awaddr_o, expected_hp_addr(dma_aw_cache_id_i, dma_aw_addr_i, base),
                     "hp0 write address");
          check_addr(hp0_araddr_o, expected_hp_addr(dma_ar_cache_id_i, dma_ar_addr_i, base),
                     "hp0 read address");
          check_level(hp0_awvalid_o, dma_aw_v_i, "hp0 write valid");
          check_level(hp0_arvalid_o, dma_ar_v_i, "hp0 read valid");
          check_level(dma_aw_ready_o, hp0_awready_i, "dma write ready");
          check_level(dma_ar_ready_o, hp0_arready_i, "dma read ready");
          next_cycle();
        end
      finish_test("dram remap");

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
        $display("STATUS: PASS");
      else
        $display("STATUS: FAIL");
      $finish;
    end

  initial
    begin
      #(clk_period_lp * (num_tests_lp * cycles_per_test_lp + reset_cycles_lp));
      $display("watchdog expired before the tests finished");
      $display("STATUS: FAIL");
      $finish;
    end

endmodule

/* hdl/zynq_ctrl_top.sv */
module zynq_ctrl_top
  #(parameter int fifo_els_p    = 4
    , parameter int reset_depth_p = 3
    )
  (  input  logic                      aclk
   , input  logic                      arst_n_i

   , input  zynq_ctrl_pkg::axil_addr_t gp0_awaddr_i
   , input  logic                      gp0_awvalid_i
   , output logic                      gp0_awready_o
   , input  zynq_ctrl_pkg::word_t      gp0_wdata_i
   , input  logic                      gp0_wvalid_i
   , output logic                      gp0_wready_o
   , output zynq_ctrl_pkg::axil_resp_t gp0_bresp_o
   , output logic                      gp0_bvalid_o
   , input  logic                      gp0_bready_i
   , input  zynq_ctrl_pkg::axil_addr_t gp0_araddr_i
   , input  logic                      gp0_arvalid_i
   , output logic                      gp0_arready_o
   , output zynq_ctrl_pkg::word_t      gp0_rdata_o
   , output zynq_ctrl_pkg::axil_resp_t gp0_rresp_o
   , output logic                      gp0_rvalid_o
   , input  logic                      gp0_rready_i

   , output zynq_ctrl_pkg::word_t      host_req_data_o
   , output logic                      host_req_v_o
   , input  logic                      host_req_ready_i

   , input  zynq_ctrl_pkg::word_t      mc_req_data_i
   , input  logic                      mc_req_v_i
   , output logic                      mc_req_ready_o

   , input  zynq_ctrl_pkg::cache_id_t  dma_aw_cache_id_i
   , input  zynq_ctrl_pkg::llc_addr_t  dma_aw_addr_i
   , input  logic                      dma_aw_v_i
   , output logic                      dma_aw_ready_o
   , input  zynq_ctrl_pkg::cache_id_t  dma_ar_cache_id_i
   , input  zynq_ctrl_pkg::llc_addr_t  dma_ar_addr_i
   , input  logic                      dma_ar_v_i
   , output logic                      dma_ar_ready_o

   , output zynq_ctrl_pkg::hp_addr_t   hp0_awaddr_o
   , output logic                      hp0_awvalid_o
   , input  logic                      hp0_awready_i
   , output zynq_ctrl_pkg::hp_addr_t   hp0_araddr_o
   , output logic                      hp0_arvalid_o
   , input  logic                      hp0_arready_i

   , output logic                      sys_reset_n_o
   );
  import zynq_ctrl_pkg::*;

  logic      ctrl_lo;
  hp_addr_t  dram_base_lo;
  rom_addr_t rom_addr_lo;
  word_t     rom_data_li;
  word_t     p2l_data_lo, l2p_data_li;
  logic      p2l_v_lo, p2l_ready_li;
  logic      l2p_v_li, l2p_yumi_lo;

  axil_csr_slave
   csr
    (.aclk(aclk)
     ,.arst_n_i(arst_n_i)
     ,.gp0_awaddr_i(gp0_awaddr_i)
     ,.gp0_awvalid_i(gp0_awvalid_i)
     ,.gp0_awready_o(gp0_awready_o)
     ,.gp0_wdata_i(gp0_wdata_i)
     ,.gp0_wvalid_i(gp0_wvalid_i)
     ,.gp0_wready_o(gp0_wready_o)
     ,.gp0_bresp_o(gp0_bresp_o)
     ,.gp0_bvalid_o(gp0_bvalid_o)
     ,.gp0_bready_i(gp0_bready_i)
     ,.gp0_araddr_i(gp0_araddr_i)
     ,.gp0_arvalid_i(gp0_arvalid_i)
     ,.gp0_arready_o(gp0_arready_o)
     ,.gp0_rdata_o(gp0_rdata_o)
     ,.gp0_rresp_o(gp0_rresp_o)
     ,.gp0_rvalid_o(gp0_rvalid_o)
     ,.gp0_rready_i(gp0_rready_i)
     ,.ctrl_o(ctrl_lo)
     ,.dram_base_o(dram_base_lo)
     ,.rom_addr_o(rom_addr_lo)
     ,.rom_data_i(rom_data_li)
     ,.p2l_data_o(p2l_data_lo)
     ,.p2l_v_o(p2l_v_lo)
     ,.p2l_ready_i(p2l_ready_li)
     ,.l2p_data_i(l2p_data_li)
     ,.l2p_v_i(l2p_v_li)
     ,.l2p_yumi_o(l2p_yumi_lo)
     );

  // ps to pl, drains to the host request port
  word_fifo
   #(.fifo_els_p(fifo_els_p))
   ps_to_pl_fifo
    (.aclk(aclk)
     ,.arst_n_i(arst_n_i)
     ,.data_i(p2l_data_lo)
     ,.v_i(p2l_v_lo)
     ,.ready_o(p2l_ready_li)
     ,.data_o(host_req_data_o)
     ,.v_o(host_req_v_o)
     ,.ready_i(host_req_ready_i)
     );

  // pl to ps, filled by manycore requests
  word_fifo
   #(.fifo_els_p(fifo_els_p))
   pl_to_ps_fifo
    (.aclk(aclk)
     ,.arst_n_i(arst_n_i)
     ,.data_i(mc_req_data_i)
     ,.v_i(mc_req_v_i)
     ,.ready_o(mc_req_ready_o)
     ,.data_o(l2p_data_li)
     ,.v_o(l2p_v_li)
     ,.ready_i(l2p_yumi_lo)
     );

  reset_delay_chain
   #(.reset_depth_p(reset_depth_p))
   reset_dff
    (.aclk(aclk)
     ,.arst_n_i(arst_n_i)
     ,.reset_n_i(ctrl_lo)
     ,.reset_n_o(sys_reset_n_o)
     );

  config_rom
   configuration_rom
    (.addr_i(rom_addr_lo)
     ,.data_o(rom_data_li)
     );

  dram_addr_remap
   remap
    (.dram_base_i(dram_base_lo)
     ,.aw_cache_id_i(dma_aw_cache_id_i)
     ,.aw_addr_i(dma_aw_addr_i)
     ,.aw_addr_o(hp0_awaddr_o)
     ,.ar_cache_id_i(dma_ar_cache_id_i)
     ,.ar_addr_i(dma_ar_addr_i)
     ,.ar_addr_o(hp0_araddr_o)
     );

  // hp0 address handshakes pass straight through
  assign hp0_awvalid_o  = dma_aw_v_i;
  assign hp0_arvalid_o  = dma_ar_v_i;
  assign dma_aw_ready_o = hp0_awready_i;
  assign dma_ar_ready_o = hp0_arready_i;

endmodule

/* hdl/axil_csr_slave.sv */
module axil_csr_slave
  (  input  logic                       aclk
   , input  logic                       arst_n_i

   , input  zynq_ctrl_pkg::axil_addr_t  gp0_awaddr_i
   , input  logic                       gp0_awvalid_i
   , output logic                       gp0_awready_o
   , input  zynq_ctrl_pkg::word_t       gp0_wdata_i
   , input  logic                       gp0_wvalid_i
   , output logic                       gp0_wready_o
   , output zynq_ctrl_pkg::axil_resp_t  gp0_bresp_o
   , output logic                       gp0_bvalid_o
   , input  logic                       gp0_bready_i

   , input  zynq_ctrl_pkg::axil_addr_t  gp0_araddr_i
   , input  logic                       gp0_arvalid_i
   , output logic                       gp0_arready_o
   , output zynq_ctrl_pkg::word_t       gp0_rdata_o
   , output zynq_ctrl_pkg::axil_resp_t  gp0_rresp_o
   , output logic                       gp0_rvalid_o
   , input  logic                       gp0_rready_i

   , output logic                       ctrl_o
   , output zynq_ctrl_pkg::word_t       dram_base_o
   , output zynq_ctrl_pkg::rom_addr_t   rom_addr_o
   , input  zynq_ctrl_pkg::word_t       rom_data_i

   , output zynq_ctrl_pkg::word_t       p2l_data_o
   , output logic                       p2l_v_o
   , input  logic                       p2l_ready_i

   , input  zynq_ctrl_pkg::word_t       l2p_data_i
   , input  logic                       l2p_v_i
   , output logic                       l2p_yumi_o
   );
  import zynq_ctrl_pkg::*;

  word_t      ctrl_r, dram_base_r, rom_addr_r;
  logic       bvalid_r, rvalid_r;
  axil_resp_t bresp_r, rresp_r;
  word_t      rdata_r;

  reg_idx_t   wr_idx, rd_idx;
  logic       wr_fire, rd_fire;
  logic       push_sel, pop_sel;
  axil_resp_t wr_resp, rd_resp;
  word_t      rd_word;

  //////////////////////////////////////////////////
  // write channel
  //////////////////////////////////////////////////

  // aw and w are taken together, only while no response is pending
  assign wr_idx        = gp0_awaddr_i[axil_addr_width_c-1:2];
  assign wr_fire       = gp0_awvalid_i & gp0_wvalid_i & ~bvalid_r;
  assign gp0_awready_o = wr_fire;
  assign gp0_wready_o  = wr_fire;

  assign push_sel   = (wr_idx == reg_ps_to_pl_c);
  assign p2l_data_o = gp0_wdata_i;
  assign p2l_v_o    = wr_fire & push_sel;
  // full fifo drops the word
  assign wr_resp    = (push_sel & ~p2l_ready_i) ? resp_slverr_c : resp_okay_c;

  always_ff @(posedge aclk or negedge arst_n_i)
    if (!arst_n_i)
      begin
        ctrl_r      <= '0;
        dram_base_r <= '0;
        rom_addr_r  <= '0;
        bvalid_r    <= 1'b0;
        bresp_r     <= resp_okay_c;
      end
    else if (wr_fire)
      begin
        case (wr_idx)
          reg_ctrl_c:      ctrl_r      <= gp0_wdata_i;
          reg_dram_base_c: dram_base_r <= gp0_wdata_i;
          reg_rom_addr_c:  rom_addr_r  <= gp0_wdata_i;
          default: ;
        endcase
        bvalid_r <= 1'b1;
        bresp_r  <= wr_resp;
      end
    else if (gp0_bready_i)
      bvalid_r <= 1'b0;

  assign gp0_bvalid_o = bvalid_r;
  assign gp0_bresp_o  = bresp_r;

  //////////////////////////////////////////////////
  // read channel
  //////////////////////////////////////////////////

  assign rd_idx        = gp0_araddr_i[axil_addr_width_c-1:2];
  assign rd_fire       = gp0_arvalid_i & ~rvalid_r;
  assign gp0_arready_o = ~rvalid_r;

  // pop only when a word is there
  assign pop_sel    = (rd_idx == reg_pl_to_ps_c);
  assign l2p_yumi_o = rd_fire & pop_sel & l2p_v_i;

  always_comb
    begin
      rd_word = '0;
      rd_resp = resp_okay_c;
      case (rd_idx)
        reg_ctrl_c:        rd_word = ctrl_r;
        reg_dram_base_c:   rd_word = dram_base_r;
        reg_rom_addr_c:    rd_word = rom_addr_r;
        reg_rom_data_c:    rd_word = rom_data_i;
        // bit 0 data waiting for the ps, bit 1 room toward the pl
        reg_fifo_status_c: rd_word = word_t'({p2l_ready_i, l2p_v_i});
        reg_pl_to_ps_c:
          if (l2p_v_i)
            rd_word = l2p_data_i;
          else
            rd_resp = resp_slverr_c;
        default: ;
      endcase
    end

  always_ff @(posedge aclk or negedge arst_n_i)
    if (!arst_n_i)
      begin
        rvalid_r <= 1'b0;
        rdata_r  <= '0;
        rresp_r  <= resp_okay_c;
      end
    else if (rd_fire)
      begin
        rvalid_r <= 1'b1;
        rdata_r  <= rd_word;
        rresp_r  <= rd_resp;
      end
    else if (gp0_rready_i)
      rvalid_r <= 1'b0;

  assign gp0_rvalid_o = rvalid_r;
  assign gp0_rdata_o  = rdata_r;
  assign gp0_rresp_o  = rresp_r;

  assign ctrl_o      = ctrl_r[0];
  assign dram_base_o = dram_base_r;
  assign rom_addr_o  = rom_addr_r[$clog2(rom_els_c)-1:0];

  // responses are held steady until the master takes them
  bvalid_hold_a : assert property (@(posedge aclk) disable iff (!arst_n_i)
    gp0_bvalid_o && !gp0_bready_i |=> gp0_bvalid_o && $stable(gp0_bresp_o));

  rvalid_hold_a : assert property (@(posedge aclk) disable iff (!arst_n_i)
    gp0_rvalid_o && !gp0_rready_i |=>
      gp0_rvalid_o && $stable(gp0_rdata_o) && $stable(gp0_rresp_o));

endmodule

/* hdl/dram_addr_remap.sv */
module dram_addr_remap
  (  input  zynq_ctrl_pkg::hp_addr_t  dram_base_i

   , input  zynq_ctrl_pkg::cache_id_t aw_cache_id_i
   , input  zynq_ctrl_pkg::llc_addr_t aw_addr_i
   , output zynq_ctrl_pkg::hp_addr_t  aw_addr_o

   , input  zynq_ctrl_pkg::cache_id_t ar_cache_id_i
   , input  zynq_ctrl_pkg::llc_addr_t ar_addr_i
   , output zynq_ctrl_pkg::hp_addr_t  ar_addr_o
   );
  import zynq_ctrl_pkg::*;

  // line address bits kept below the cache id
  localparam int line_bits_lp = llc_addr_width_c - lg_num_dma_c;

  // cache id on top of the line address, then offset into dram
  function automatic hp_addr_t remap
    (input cache_id_t id
     , input llc_addr_t addr
     , input hp_addr_t base
     );
    llc_addr_t hashed;
    hashed = {id, addr[line_bits_lp-1:0]};
    return hp_addr_t'(hashed) + base;
  endfunction

  assign aw_addr_o = remap(aw_cache_id_i, aw_addr_i, dram_base_i);
  assign ar_addr_o = remap(ar_cache_id_i, ar_addr_i, dram_base_i);

endmodule

/* hdl/config_rom.sv */
module config_rom
  (  input  zynq_ctrl_pkg::rom_addr_t addr_i
   , output zynq_ctrl_pkg::word_t     data_o
   );
  import zynq_ctrl_pkg::*;

  word_t rom_table [rom_els_c];

  // one entry per address, contents come from the shared rom_word
  for (genvar k = 0; k < rom_els_c; k++)
    begin : entry
      assign rom_table[k] = rom_word(rom_addr_t'(k));
    end

  assign data_o = rom_table[addr_i];

endmodule

/* hdl/reset_delay_chain.sv */
module reset_delay_chain
  #(parameter int reset_depth_p = 3
    )
  (  input  logic aclk
   , input  logic arst_n_i
   , input  logic reset_n_i
   , output logic reset_n_o
   );

  logic [reset_depth_p-1:0] chain_r;

  // system stays in reset while the chain is cleared
  always_ff @(posedge aclk or negedge arst_n_i)
    if (!arst_n_i)
      chain_r <= '0;
    else
      begin
        chain_r[0] <= reset_n_i;
        for (int i = 1; i < reset_depth_p; i++)
          chain_r[i] <= chain_r[i-1];
      end

  assign reset_n_o = chain_r[reset_depth_p-1];

endmodule

/* hdl/word_fifo.sv */
module word_fifo
  #(parameter int fifo_els_p = 4
    )
  (  input  logic                 aclk
   , input  logic                 arst_n_i
   , input  zynq_ctrl_pkg::word_t data_i
   , input  logic                 v_i
   , output logic                 ready_o
   , output zynq_ctrl_pkg::word_t data_o
   , output logic                 v_o
   , input  logic                 ready_i
   );
  import zynq_ctrl_pkg::*;

  localparam int ptr_width_lp   = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
  localparam int count_width_lp = $clog2(fifo_els_p + 1);

  word_t                     mem [fifo_els_p];
  logic [ptr_width_lp-1:0]   wr_ptr_r, rd_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic                      enq, deq;

  // pointer wrap, depth need not be a power of two
  function automatic logic [ptr_width_lp-1:0] ptr_next(input logic [ptr_width_lp-1:0] p);
    if (p == ptr_width_lp'(fifo_els_p - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign ready_o = (count_r != count_width_lp'(fifo_els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem[rd_ptr_r];
  assign enq     = v_i & ready_o;
  assign deq     = v_o & ready_i;

  always_ff @(posedge aclk)
    if (enq)
      mem[wr_ptr_r] <= data_i;

  always_ff @(posedge aclk or negedge arst_n_i)
    if (!arst_n_i)
      begin
        wr_ptr_r <= '0;
        rd_ptr_r <= '0;
        count_r  <= '0;
      end
    else
      begin
        if (enq)
          wr_ptr_r <= ptr_next(wr_ptr_r);
        if (deq)
          rd_ptr_r <= ptr_next(rd_ptr_r);
        count_r <= count_r + count_width_lp'(enq) - count_width_lp'(deq);
      end

  count_within_depth_a : assert property (@(posedge aclk) disable iff (!arst_n_i)
    count_r <= count_width_lp'(fifo_els_p));

endmodule

/* hdl/zynq_ctrl_pkg.sv */
package zynq_ctrl_pkg;

  // gp0 bus
  localparam int axil_data_width_c = 32;
  localparam int axil_addr_width_c = 10;
  localparam int reg_idx_width_c   = axil_addr_width_c - 2;

  typedef logic [axil_data_width_c-1:0] word_t;
  typedef logic [axil_addr_width_c-1:0] axil_addr_t;
  typedef logic [1:0]                   axil_resp_t;
  typedef logic [reg_idx_width_c-1:0]   reg_idx_t;

  localparam axil_resp_t resp_okay_c   = 2'b00;
  localparam axil_resp_t resp_slverr_c = 2'b10;

  // word offsets, byte address is four times these
  localparam reg_idx_t reg_ctrl_c        = reg_idx_t'(0);
  localparam reg_idx_t reg_dram_base_c   = reg_idx_t'(1);
  localparam reg_idx_t reg_rom_addr_c    = reg_idx_t'(2);
  localparam reg_idx_t reg_rom_data_c    = reg_idx_t'(3);
  localparam reg_idx_t reg_fifo_status_c = reg_idx_t'(4);
  localparam reg_idx_t reg_ps_to_pl_c    = reg_idx_t'(5);
  localparam reg_idx_t reg_pl_to_ps_c    = reg_idx_t'(6);

  // machine configuration table
  localparam int rom_els_c = 8;
  typedef logic [$clog2(rom_els_c)-1:0] rom_addr_t;

  function automatic word_t rom_word(input rom_addr_t k);
    logic [15:0] kw;
    kw = 16'(k);
    return {8'hb5, 8'(k), kw * kw + 16'd1};
  endfunction

  // cache side dma and hp0 addressing
  localparam int llc_addr_width_c = 24;
  localparam int lg_num_dma_c     = 2;
  localparam int hp_addr_width_c  = 32;

  typedef logic [llc_addr_width_c-1:0] llc_addr_t;
  typedef logic [lg_num_dma_c-1:0]     cache_id_t;
  typedef logic [hp_addr_width_c-1:0]  hp_addr_t;

endpackage
